//--- design/minimac_rx_pkg.sv
/*
 * Shared types and constants of the receive MAC
 * Word and byte types, slot geometry, APB register offsets,
 * end-of-frame word encodings and the slot state enum
 */
`default_nettype none

package minimac_rx_pkg;

	typedef logic [7:0] rx_byte_t;  // One byte as assembled from two MII nibbles
	typedef logic [8:0] rx_word_t;  // Bit 8 is eof, then bit 0 carries the error flag

	localparam int NUM_SLOTS  = 4;
	localparam int SLOT_DEPTH = 64;  // 63 data bytes and room for the end-of-frame word
	localparam int SLOT_PW    = $clog2(NUM_SLOTS);
	localparam int SLOT_AW    = $clog2(SLOT_DEPTH);

	typedef logic [SLOT_PW-1:0] slot_ptr_t;   // Index of a frame slot
	typedef logic [SLOT_AW-1:0] slot_addr_t;  // Word address inside one slot
	typedef logic [7:0]         drop_cnt_t;   // Saturating count of dropped frames

	// End-of-frame words as they sit in a slot
	localparam rx_word_t EOF_OK  = 9'h100;
	localparam rx_word_t EOF_ERR = 9'h101;

	// APB register map, paddr is 4 bits wide
	localparam logic [3:0] REG_STATUS = 4'h0;  // Ready bitmap and drop count
	localparam logic [3:0] REG_DATA   = 4'h4;  // Pops one word of the oldest frame
	localparam logic [3:0] REG_CLEAR  = 4'h8;  // Bit 0 written high clears the drop count

	typedef enum logic [1:0] {
		SLOT_EMPTY,    // Free for the next frame
		SLOT_FILLING,  // Frame being written
		SLOT_READY     // Complete frame waiting to be read
	} slot_state_t;

endpackage

`default_nettype wire

//--- design/rx_word_if.sv
/*
 * rx_word_if carries frame words from the framer to the dispatcher and on to the slots
 * slot_rd_if is the read port of one slot towards the APB reader
 */
`timescale 1ns/1ps
`default_nettype none

interface rx_word_if;
	import minimac_rx_pkg::*;

	logic     valid;   // One cycle per word
	rx_word_t word;
	logic     sof;     // First word of a frame
	logic     accept;  // Sampled with sof to keep or drop the frame

	modport framer   (output valid, output word, output sof);
	modport receive  (input valid, input word, input sof, output accept);
	modport dispatch (output valid, output word, output sof, input accept);
	modport slot     (input valid, input word, input sof, output accept);
endinterface

interface slot_rd_if;
	import minimac_rx_pkg::*;

	logic     ready;    // Slot holds a complete frame
	rx_word_t rd_word;  // Word at the read pointer
	logic     pop;      // Advances the read pointer
	logic     free;     // Slot empty, usable for a new frame

	modport slot   (output ready, output rd_word, input pop, output free);
	modport reader (input ready, input rd_word, output pop);
endinterface

`default_nettype wire

//--- design/mii_rx_framer.sv
/*
 * MII receive framer
 * Joins nibble pairs into bytes, low nibble first, flags the first word of a frame
 * and closes every frame with an end-of-frame word carrying the error flag
 */
`timescale 1ns/1ps
`default_nettype none

module mii_rx_framer (
	input  logic       phy_rx_clk,
	input  logic       rx_rst2,
	input  logic [3:0] phy_rx_data,
	input  logic       phy_dv,
	input  logic       phy_rx_er,
	rx_word_if.framer  out
);
	import minimac_rx_pkg::*;

	logic [3:0] lo_nibble;   // Low half of the byte being assembled
	logic       hi_nibble;   // Next nibble completes a byte
	logic       abort;       // Frame already closed by an error word
	logic       first_word;  // Next emitted word opens a frame
	logic       phy_dv_r;    // Previous phy_dv, for the falling edge
	logic       valid_q;
	logic       sof_q;
	rx_word_t   word_q;      // Payload only, qualified by valid_q

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			valid_q    <= 1'b0;
			sof_q      <= 1'b0;
			hi_nibble  <= 1'b0;
			abort      <= 1'b0;
			first_word <= 1'b1;
			phy_dv_r   <= 1'b0;
		end else begin
			valid_q  <= 1'b0;  // Every word is a single-cycle pulse
			sof_q    <= 1'b0;
			phy_dv_r <= phy_dv;

			if (phy_dv && !abort) begin
				if (phy_rx_er) begin
					// Close the frame at once and ignore the rest of it
					valid_q    <= 1'b1;
					sof_q      <= first_word;  // Set when the error hits before any byte
					word_q     <= EOF_ERR;
					first_word <= 1'b0;
					abort      <= 1'b1;
					hi_nibble  <= 1'b0;
				end else if (!hi_nibble) begin
					lo_nibble <= phy_rx_data;
					hi_nibble <= 1'b1;
				end else begin
					valid_q    <= 1'b1;
					sof_q      <= first_word;
					word_q     <= {1'b0, phy_rx_data, lo_nibble};
					first_word <= 1'b0;
					hi_nibble  <= 1'b0;
				end
			end else if (phy_dv_r && !phy_dv) begin
				// End of frame, a dangling low nibble is simply lost
				if (!abort) begin
					valid_q <= 1'b1;
					sof_q   <= first_word;  // A frame with no whole byte is only its eof
					word_q  <= EOF_OK;
				end
				abort      <= 1'b0;
				hi_nibble  <= 1'b0;
				first_word <= 1'b1;
			end
		end
	end

	assign out.valid = valid_q;
	assign out.word  = word_q;
	assign out.sof   = sof_q;

	// Two words in a row only happen when the last byte is followed by its eof
	a_valid_spacing: assert property (@(posedge phy_rx_clk) disable iff (rx_rst2)
		valid_q |=> (!valid_q || (word_q[8] && !$past(word_q[8]))));

endmodule

`default_nettype wire

//--- design/rx_slot_dispatch.sv
/*
 * Frame dispatcher
 * Hands each new frame to the next slot in rotation, drops frames whose
 * slot is still occupied and counts them in a saturating counter
 */
`timescale 1ns/1ps
`default_nettype none

module rx_slot_dispatch (
	input  logic                                   phy_rx_clk,
	input  logic                                   rx_rst2,
	rx_word_if.receive                             in,
	rx_word_if.dispatch                            slot_out [minimac_rx_pkg::NUM_SLOTS],
	input  logic [minimac_rx_pkg::NUM_SLOTS-1:0]   slot_free,
	output minimac_rx_pkg::drop_cnt_t              drop_count,
	input  logic                                   clear_drops
);
	import minimac_rx_pkg::*;

	slot_ptr_t            cur_slot;    // Slot that gets the next frame
	logic                 routing;     // Words of a kept frame are in flight
	logic [NUM_SLOTS-1:0] slot_acc;    // Accept flags gathered from the slots
	logic                 route_valid;

	assign in.accept = slot_acc[cur_slot];

	// The sof word decides by itself, later words follow that decision
	assign route_valid = in.valid && (in.sof ? in.accept : routing);

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_route
		assign slot_acc[i]       = slot_out[i].accept;
		assign slot_out[i].valid = route_valid && (cur_slot == slot_ptr_t'(i));
		assign slot_out[i].word  = in.word;
		assign slot_out[i].sof   = in.sof;
	end

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			cur_slot   <= '0;
			routing    <= 1'b0;
			drop_count <= '0;
		end else begin
			if (in.valid && in.sof) begin
				if (in.accept) begin
					if (in.word[8])
						cur_slot <= cur_slot + slot_ptr_t'(1);  // Frame that is only an eof
					else
						routing <= 1'b1;
				end else begin
					routing <= 1'b0;  // Whole frame discarded, rotation stays put
				end
			end else if (in.valid && in.word[8] && routing) begin
				routing  <= 1'b0;
				cur_slot <= cur_slot + slot_ptr_t'(1);
			end

			if (clear_drops)
				drop_count <= '0;
			else if (in.valid && in.sof && !in.accept && drop_count != '1)
				drop_count <= drop_count + drop_cnt_t'(1);  // Saturates at 255
		end
	end

	// A slot that was handed a sof word must have taken it and left SLOT_EMPTY
	a_route_free: assert property (@(posedge phy_rx_clk) disable iff (rx_rst2)
		(in.valid && in.sof && in.accept) |=> !slot_free[$past(cur_slot)]);

endmodule

`default_nettype wire

//--- design/rx_slot_buffer.sv
/*
 * One frame slot
 * 64-word buffer filled from the dispatcher, truncated with an error
 * end-of-frame word on overflow and drained word by word by the reader
 */
`timescale 1ns/1ps
`default_nettype none

module rx_slot_buffer (
	input  logic      phy_rx_clk,
	input  logic      rx_rst2,
	rx_word_if.slot   wr,
	slot_rd_if.slot   rd
);
	import minimac_rx_pkg::*;

	rx_word_t    mem [SLOT_DEPTH];
	slot_addr_t  wr_ptr;
	slot_addr_t  rd_ptr;
	slot_state_t state;
	logic        wr_en;
	logic        overflow;  // Data byte with no room left for its eof
	logic        wr_last;   // This write closes the frame in the slot
	rx_word_t    wr_data;

	// Only the last entry is left and the frame still sends data
	assign overflow = (wr_ptr == slot_addr_t'(SLOT_DEPTH - 1)) && !wr.word[8];
	assign wr_data  = overflow ? EOF_ERR : wr.word;
	assign wr_last  = wr.word[8] || overflow;

	// An empty slot only starts on sof, so leftovers of a truncated frame fall away
	assign wr_en = wr.valid &&
		((state == SLOT_EMPTY && wr.sof) || state == SLOT_FILLING);

	always_ff @(posedge phy_rx_clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			state  <= SLOT_EMPTY;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			case (state)
				SLOT_EMPTY, SLOT_FILLING: begin
					if (wr_en) begin
						wr_ptr <= wr_ptr + slot_addr_t'(1);
						state  <= wr_last ? SLOT_READY : SLOT_FILLING;
					end
				end
				SLOT_READY: begin
					if (rd.pop) begin
						rd_ptr <= rd_ptr + slot_addr_t'(1);
						if (rd.rd_word[8]) begin  // Frame fully read, slot reusable
							state  <= SLOT_EMPTY;
							rd_ptr <= '0;
							wr_ptr <= '0;
						end
					end
				end
				default: state <= SLOT_EMPTY;
			endcase
		end
	end

	assign wr.accept  = (state == SLOT_EMPTY);
	assign rd.free    = (state == SLOT_EMPTY);
	assign rd.ready   = (state == SLOT_READY);
	assign rd.rd_word = mem[rd_ptr];  // Presented ahead of the pop

	// The reader must never pop a slot that holds no complete frame
	a_pop_ready: assert property (@(posedge phy_rx_clk) disable iff (rx_rst2)
		rd.pop |-> (state == SLOT_READY));

endmodule

`default_nettype wire

//--- design/apb_rx_reader.sv
/*
 * APB register block of the receive MAC
 * STATUS shows ready slots and the drop count, DATA pops the oldest frame
 * word by word, CLEAR resets the drop count
 */
`timescale 1ns/1ps
`default_nettype none

module apb_rx_reader (
	input  logic                       phy_rx_clk,
	input  logic                       rx_rst2,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [3:0]                 paddr,
	input  logic [31:0]                pwdata,
	output logic [31:0]                prdata,
	output logic                       pready,
	output logic                       pslverr,
	slot_rd_if.reader                  slot_rd [minimac_rx_pkg::NUM_SLOTS],
	input  minimac_rx_pkg::drop_cnt_t  drop_count,
	output logic                       clear_drops
);
	import minimac_rx_pkg::*;

	slot_ptr_t            rd_slot;    // Oldest slot in arrival order
	logic [NUM_SLOTS-1:0] ready_map;
	rx_word_t             slot_words [NUM_SLOTS];
	rx_word_t             cur_word;
	logic                 cur_ready;
	logic                 access;     // APB access phase, no wait states
	logic                 pop_data;
	logic                 addr_ok;

	assign access    = psel && penable;
	assign cur_ready = ready_map[rd_slot];
	assign cur_word  = slot_words[rd_slot];

	// A DATA read on an idle slot returns zero and leaves the slot alone
	assign pop_data = access && !pwrite && (paddr == REG_DATA) && cur_ready;

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		assign ready_map[i]  = slot_rd[i].ready;
		assign slot_words[i] = slot_rd[i].rd_word;
		assign slot_rd[i].pop = pop_data && (rd_slot == slot_ptr_t'(i));
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			REG_STATUS: prdata = {16'h0, drop_count, {(8 - NUM_SLOTS){1'b0}}, ready_map};
			REG_DATA: begin
				if (cur_ready)
					prdata = {1'b1, 22'h0, cur_word};  // Bit 31 marks a real word
			end
			default: prdata = '0;
		endcase
	end

	assign pready = 1'b1;

	// Writes only go to CLEAR, reads only to STATUS, DATA and CLEAR
	assign addr_ok = pwrite ? (paddr == REG_CLEAR) :
		(paddr == REG_STATUS || paddr == REG_DATA || paddr == REG_CLEAR);
	assign pslverr = access && !addr_ok;

	assign clear_drops = access && pwrite && (paddr == REG_CLEAR) && pwdata[0];

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			rd_slot <= '0;
		end else if (pop_data && cur_word[8]) begin
			rd_slot <= rd_slot + slot_ptr_t'(1);  // Next frame sits in the next slot
		end
	end

endmodule

`default_nettype wire

//--- design/minimac_rx.sv
/*
 * Receive MAC top level
 * MII framer, frame dispatcher, four frame slots and the APB reader
 */
`timescale 1ns/1ps
`default_nettype none

module minimac_rx (
	input  logic        phy_rx_clk,
	input  logic        rx_rst2,
	input  logic [3:0]  phy_rx_data,
	input  logic        phy_dv,
	input  logic        phy_rx_er,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);
	import minimac_rx_pkg::*;

	rx_word_if frame_if ();              // Framer to dispatcher
	rx_word_if slot_wr_if [NUM_SLOTS] ();  // Dispatcher to each slot
	slot_rd_if slot_rd_if_i [NUM_SLOTS] ();  // Each slot to the reader

	logic [NUM_SLOTS-1:0] slot_free;
	drop_cnt_t            drop_count;
	logic                 clear_drops;

	mii_rx_framer framer_i (
		.phy_rx_clk  (phy_rx_clk),
		.rx_rst2     (rx_rst2),
		.phy_rx_data (phy_rx_data),
		.phy_dv      (phy_dv),
		.phy_rx_er   (phy_rx_er),
		.out         (frame_if)
	);

	rx_slot_dispatch dispatch_i (
		.phy_rx_clk  (phy_rx_clk),
		.rx_rst2     (rx_rst2),
		.in          (frame_if),
		.slot_out    (slot_wr_if),
		.slot_free   (slot_free),
		.drop_count  (drop_count),
		.clear_drops (clear_drops)
	);

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		rx_slot_buffer slot_i (
			.phy_rx_clk (phy_rx_clk),
			.rx_rst2    (rx_rst2),
			.wr         (slot_wr_if[i]),
			.rd         (slot_rd_if_i[i])
		);
		assign slot_free[i] = slot_rd_if_i[i].free;
	end

	apb_rx_reader reader_i (
		.phy_rx_clk  (phy_rx_clk),
		.rx_rst2     (rx_rst2),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.slot_rd     (slot_rd_if_i),
		.drop_count  (drop_count),
		.clear_drops (clear_drops)
	);

endmodule

`default_nettype wire

//--- tests/minimac_rx_checker.sv
/*
 * Reference model of the receive MAC built from the MII and APB pins
 * Predicts slot contents, drops and register reads, and compares every APB access
 */
`timescale 1ns/1ps
`default_nettype none

module minimac_rx_checker (
	input  logic        phy_rx_clk,
	input  logic        rx_rst2,
	input  logic [3:0]  phy_rx_data,
	input  logic        phy_dv,
	input  logic        phy_rx_er,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic [31:0] prdata,
	input  logic        pready,
	input  logic        pslverr,
	output int          err_count,
	output int          check_count
);
	logic [8:0] frame_q [$];     // Words of the frame on the wire
	logic [8:0] slot_q [4][$];   // Expected contents of each slot
	logic [3:0] full;            // Slot holds a complete frame
	logic [7:0] drops;
	logic [3:0] lo;
	logic [31:0] exp_rd;
	logic [8:0] w;
	bit         hi, abort, dv_r, exp_err;
	int         wr_slot, rd_slot;

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// A frame lands in the next slot in rotation, or is dropped when that slot is busy
	task automatic close_frame(input bit err);
		int n;
		logic [8:0] fw;
		n = 0;
		frame_q.push_back({8'h80, err});
		if (full[wr_slot]) begin
			if (drops != 8'hff)
				drops++;  // Saturating like the hardware counter
		end else begin
			for (int i = 0; i < frame_q.size(); i++) begin
				fw = frame_q[i];
				if (!fw[8] && n == 63) begin
					slot_q[wr_slot].push_back(9'h101);  // Overflow closes with an error
					break;
				end
				slot_q[wr_slot].push_back(fw);
				if (fw[8])
					break;
				n++;
			end
			full[wr_slot] = 1'b1;
			wr_slot = (wr_slot + 1) % 4;
		end
		frame_q.delete();
	endtask

	initial begin
		err_count = 0;
		check_count = 0;
	end

	// Sample a quarter period after the falling edge, when all pins have settled
	always begin
		@(negedge phy_rx_clk);
		#10;
		if (rx_rst2) begin
			frame_q.delete();
			for (int s = 0; s < 4; s++)
				slot_q[s].delete();
			full = '0;
			drops = '0;
			hi = 0;
			abort = 0;
			dv_r = 0;
			wr_slot = 0;
			rd_slot = 0;
		end else begin
			if (phy_dv && !abort) begin
				if (phy_rx_er) begin
					close_frame(1'b1);  // Rest of this frame is ignored
					abort = 1;
					hi = 0;
				end else if (!hi) begin
					lo = phy_rx_data;
					hi = 1;
				end else begin
					frame_q.push_back({1'b0, phy_rx_data, lo});  // Low nibble first
					hi = 0;
				end
			end else if (dv_r && !phy_dv) begin
				if (!abort)
					close_frame(1'b0);
				abort = 0;
				hi = 0;
			end
			dv_r = phy_dv;

			if (psel && penable) begin
				exp_err = pwrite ? (paddr != 4'h8) : !(paddr inside {4'h0, 4'h4, 4'h8});
				compare("pslverr", {31'h0, pslverr}, {31'h0, exp_err});
				compare("pready", {31'h0, pready}, 32'h1);
				if (!pwrite) begin
					exp_rd = '0;
					if (paddr == 4'h0) begin
						exp_rd = {16'h0, drops, 4'h0, full};
					end else if (paddr == 4'h4 && full[rd_slot]) begin
						w = slot_q[rd_slot].pop_front();
						exp_rd = {1'b1, 22'h0, w};
						if (w[8]) begin  // Frame fully read, move to the next slot
							full[rd_slot] = 1'b0;
							rd_slot = (rd_slot + 1) % 4;
						end
					end
					compare($sformatf("read of offset %h", paddr), prdata, exp_rd);
				end else if (paddr == 4'h8 && pwdata[0]) begin
					drops = '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/minimac_rx_tb.sv
/*
 * Testbench of the receive MAC
 * Clock and reset, table of frame entries, MII and APB drivers, watchdog and summary
 */
`timescale 1ns/1ps
`default_nettype none

module minimac_rx_tb;
	localparam int N_ENTRIES = 5;
	localparam logic [3:0] ADDR_STATUS = 4'h0;
	localparam logic [3:0] ADDR_DATA   = 4'h4;
	localparam logic [3:0] ADDR_CLEAR  = 4'h8;
	localparam logic [3:0] ADDR_NONE   = 4'hc;  // Unmapped offset

	// Byte count, index of the byte hit by phy_rx_er (-1 for none) and frames per entry
	int ent_bytes [N_ENTRIES]  = '{20, 16, 10, 8, 70};
	int ent_err [N_ENTRIES]    = '{-1, 5, -1, -1, -1};
	int ent_frames [N_ENTRIES] = '{1, 1, 3, 6, 1};

	logic        phy_rx_clk, rx_rst2, phy_dv, phy_rx_er;
	logic [3:0]  phy_rx_data, paddr;
	logic        psel, penable, pwrite, pready, pslverr;
	logic [31:0] pwdata, prdata;
	int          err_count, check_count;

	minimac_rx minimac_rx_i (.*);

	minimac_rx_checker checker_i (.*);

	initial begin
		phy_rx_clk = 1'b0;
		forever #20 phy_rx_clk = ~phy_rx_clk;
	end

	task automatic send_frame(input int nbytes, input int err_idx);
		int r;
		for (int b = 0; b < nbytes; b++) begin
			r = $urandom;
			@(negedge phy_rx_clk);
			phy_dv = 1'b1;
			phy_rx_data = r[3:0];
			phy_rx_er = (b == err_idx);  // Error lands on the low nibble of that byte
			@(negedge phy_rx_clk);
			phy_rx_data = r[7:4];
			phy_rx_er = 1'b0;
		end
		@(negedge phy_rx_clk);
		phy_dv = 1'b0;
		repeat (4) @(negedge phy_rx_clk);  // Gap leaves the frame time to become ready
	endtask

	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		@(negedge phy_rx_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge phy_rx_clk);
		penable = 1'b1;
		#10 rdata = prdata;
		@(negedge phy_rx_clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// Limit from the nibble cycles and the APB reads of the whole table
	function automatic longint run_limit();
		longint cycles;
		cycles = 200;
		for (int i = 0; i < N_ENTRIES; i++)
			cycles += ent_frames[i] * (2 * ent_bytes[i] + 6) +
				3 * (ent_frames[i] * (ent_bytes[i] + 2) + 8);
		return 2 * cycles * 40;
	endfunction

	initial begin
		#(run_limit());
		$display("Timeout: the run did not finish within the time set by the test table");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [31:0] d;
		phy_dv = 1'b0;
		phy_rx_er = 1'b0;
		phy_rx_data = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rx_rst2 = 1'b1;
		void'($urandom(32'hb7cc_14e5));
		repeat (8) @(negedge phy_rx_clk);
		rx_rst2 = 1'b0;

		for (int e = 0; e < N_ENTRIES; e++) begin
			for (int f = 0; f < ent_frames[e]; f++)
				send_frame(ent_bytes[e], ent_err[e]);
			apb_access(1'b0, ADDR_STATUS, '0, d);  // Ready bitmap and drops before draining
			do
				apb_access(1'b0, ADDR_DATA, '0, d);
			while (d[31]);  // Last read finds no slot ready
			apb_access(1'b0, ADDR_STATUS, '0, d);
			apb_access(1'b1, ADDR_CLEAR, 32'h1, d);
			apb_access(1'b0, ADDR_STATUS, '0, d);
			apb_access(1'b0, ADDR_NONE, '0, d);
			$display("Entry %0d: %0d frame(s) of %0d bytes done, %0d mismatches so far",
				e, ent_frames[e], ent_bytes[e], err_count);
		end

		$display("Summary: %0d checks, %0d mismatches", check_count, err_count);
		if (err_count == 0 && check_count > 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- minimac_rx.f
design/minimac_rx_pkg.sv
design/rx_word_if.sv
design/mii_rx_framer.sv
design/rx_slot_dispatch.sv
design/rx_slot_buffer.sv
design/apb_rx_reader.sv
design/minimac_rx.sv
tests/minimac_rx_checker.sv
tests/minimac_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive MAC simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f minimac_rx.f --top-module minimac_rx_tb \
	--Mdir obj_dir -o minimac_rx_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/minimac_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
